/* pifo_queue.f */
+incdir+hw
hw/pifo_pkg.sv
hw/pifo_ctrl.sv
hw/pifo_cell.sv
hw/pifo_queue.sv
bench/pifo_queue_tb.sv

/* Makefile */
# Verilator flow for the PIFO queue
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
FILELIST  ?= pifo_queue.f
TB_TOP    ?= pifo_queue_tb
RTL_TOP   ?= pifo_queue
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
PASS_TEXT ?= Verification passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)

# The simulator's exit status is not trusted, the log decides
sim: build
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) || { echo "Pass message not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/pifo_vectors.txt */
// Columns in hex: test insert remove rank meta exp_valid exp_rank exp_meta exp_count exp_full
// Expected values hold after the clock edge on which the line's inputs are taken
// Test 1: reset state, remove on an empty queue
1 0 0 000 000 0 000 000 0 0
1 0 1 000 000 0 000 000 0 0
// Test 2: out of order inserts drain in rank order
2 1 0 050 101 0 000 000 1 0
2 1 0 020 102 0 000 000 2 0
2 1 0 080 103 0 000 000 3 0
2 1 0 010 104 0 000 000 4 0
2 1 0 040 105 0 000 000 5 0
2 0 1 000 000 1 010 104 4 0
2 0 1 000 000 1 020 102 3 0
2 0 1 000 000 1 040 105 2 0
2 0 1 000 000 1 050 101 1 0
2 0 1 000 000 1 080 103 0 0
2 0 0 000 000 0 000 000 0 0
// Test 3: equal ranks leave in arrival order
3 1 0 033 201 0 000 000 1 0
3 1 0 033 202 0 000 000 2 0
3 1 0 033 203 0 000 000 3 0
3 0 1 000 000 1 033 201 2 0
3 0 1 000 000 1 033 202 1 0
3 0 1 000 000 1 033 203 0 0
// Test 4: fill to eight, ninth insert is dropped
4 1 0 070 301 0 000 000 1 0
4 1 0 010 302 0 000 000 2 0
4 1 0 060 303 0 000 000 3 0
4 1 0 020 304 0 000 000 4 0
4 1 0 050 305 0 000 000 5 0
4 1 0 030 306 0 000 000 6 0
4 1 0 040 307 0 000 000 7 0
4 1 0 005 308 0 000 000 8 1
4 1 0 001 309 0 000 000 8 1
4 0 1 000 000 1 005 308 7 0
4 0 1 000 000 1 010 302 6 0
4 0 1 000 000 1 020 304 5 0
4 0 1 000 000 1 030 306 4 0
4 0 1 000 000 1 040 307 3 0
4 0 1 000 000 1 050 305 2 0
4 0 1 000 000 1 060 303 1 0
4 0 1 000 000 1 070 301 0 0
// Test 5: insert with remove on a full queue, then on an empty queue
5 1 0 140 401 0 000 000 1 0
5 1 0 100 402 0 000 000 2 0
5 1 0 160 403 0 000 000 3 0
5 1 0 120 404 0 000 000 4 0
5 1 0 170 405 0 000 000 5 0
5 1 0 110 406 0 000 000 6 0
5 1 0 150 407 0 000 000 7 0
5 1 0 130 408 0 000 000 8 1
5 1 1 125 409 1 100 402 8 1
5 0 1 000 000 1 110 406 7 0
5 0 1 000 000 1 120 404 6 0
5 0 1 000 000 1 125 409 5 0
5 0 1 000 000 1 130 408 4 0
5 0 1 000 000 1 140 401 3 0
5 0 1 000 000 1 150 407 2 0
5 0 1 000 000 1 160 403 1 0
5 0 1 000 000 1 170 405 0 0
5 1 1 200 40a 0 000 000 1 0
5 0 1 000 000 1 200 40a 0 0
5 0 0 000 000 0 000 000 0 0

/* bench/pifo_queue_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pifo_params.svh"

module pifo_queue_tb;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 16;
	localparam int DRIVE_DELAY = 2;
	localparam int CHECK_DELAY = 1;
	localparam int FIELDS = 10;
	localparam int MAX_VECTORS = 256;

	logic                        clk;
	logic                        rst;
	logic                        insert;
	logic                        remove;
	logic [`PIFO_RANK_WIDTH-1:0] rank_in;
	logic [`PIFO_META_WIDTH-1:0] meta_in;
	logic [`PIFO_RANK_WIDTH-1:0] rank_out;
	logic [`PIFO_META_WIDTH-1:0] meta_out;
	logic                        valid_out;
	logic [`PIFO_L2_DEPTH:0]     num_entries;
	logic                        full;

	// Ten fields of each vector line sit one after another
	logic [15:0] vec_mem [0:MAX_VECTORS*FIELDS-1];
	int          num_vectors;
	bit          vectors_loaded;
	int          error_count;
	int          check_count;

	pifo_queue uut
	(
		.clk         (clk),
		.rst         (rst),
		.insert      (insert),
		.remove      (remove),
		.rank_in     (rank_in),
		.meta_in     (meta_in),
		.rank_out    (rank_out),
		.meta_out    (meta_out),
		.valid_out   (valid_out),
		.num_entries (num_entries),
		.full        (full)
	);

	always #(CLK_PERIOD/2) clk = ~clk;

	task automatic check_value(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("Mismatch at %0t ns: %s expected %0h, got %0h",
				$time, name, expected, actual);
		end
	endtask

	task automatic drive_line(input int idx);
		int base;
		base = idx * FIELDS;
		insert = vec_mem[base+1][0];
		remove = vec_mem[base+2][0];
		rank_in = vec_mem[base+3][`PIFO_RANK_WIDTH-1:0];
		meta_in = vec_mem[base+4][`PIFO_META_WIDTH-1:0];
	endtask

	task automatic drive_idle();
		insert = 1'b0;
		remove = 1'b0;
		rank_in = '0;
		meta_in = '0;
	endtask

	// Drained entry only matters when a remove was taken
	// Rank and meta are taken at the width of their ports, as when driven
	task automatic compare_outputs(input int idx);
		int base;
		base = idx * FIELDS;
		check_value("valid_out", vec_mem[base+5], 16'(valid_out));
		if (vec_mem[base+5][0])
		begin
			check_value("rank_out",
				16'(vec_mem[base+6][`PIFO_RANK_WIDTH-1:0]), 16'(rank_out));
			check_value("meta_out",
				16'(vec_mem[base+7][`PIFO_META_WIDTH-1:0]), 16'(meta_out));
		end
		check_value("num_entries", vec_mem[base+8], 16'(num_entries));
		check_value("full", vec_mem[base+9], 16'(full));
	endtask

	task automatic report_test(input int test_num, input int cycles, input int errors);
		if (errors == 0)
		begin
			$display("Test %0d: %0d cycles, no mismatches", test_num, cycles);
		end
		else
		begin
			$display("Test %0d: %0d cycles, %0d mismatches", test_num, cycles, errors);
		end
	endtask

	initial
	begin
		int cur_test;
		int line_test;
		int test_start_errors;
		int test_cycles;
		int tests_done;
		clk = 1'b0;
		rst = 1'b1;
		drive_idle();
		error_count = 0;
		check_count = 0;
		tests_done = 0;
		cur_test = 0;
		test_start_errors = 0;
		test_cycles = 0;

		// Unwritten slots get a test number above 0xff, which marks the end
		for (int a = 0; a < MAX_VECTORS*FIELDS; a++)
		begin
			vec_mem[a] = ~16'(a);
		end
		$readmemh("bench/pifo_vectors.txt", vec_mem);
		num_vectors = 0;
		while (num_vectors < MAX_VECTORS && vec_mem[num_vectors*FIELDS] <= 16'h00ff)
		begin
			num_vectors++;
		end
		vectors_loaded = 1'b1;
		if (num_vectors == 0)
		begin
			$display("No stimulus vectors could be read from bench/pifo_vectors.txt");
			error_count++;
		end

		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b0;
		if (num_vectors > 0)
		begin
			drive_line(0);
			cur_test = int'(vec_mem[0]);
		end

		for (int k = 0; k < num_vectors; k++)
		begin
			@(posedge clk);
			#CHECK_DELAY;
			line_test = int'(vec_mem[k*FIELDS]);
			if (line_test != cur_test)
			begin
				report_test(cur_test, test_cycles, error_count - test_start_errors);
				tests_done++;
				cur_test = line_test;
				test_start_errors = error_count;
				test_cycles = 0;
			end
			compare_outputs(k);
			test_cycles++;
			#(DRIVE_DELAY - CHECK_DELAY);
			if (k + 1 < num_vectors)
			begin
				drive_line(k + 1);
			end
			else
			begin
				drive_idle();
			end
		end

		if (num_vectors > 0)
		begin
			report_test(cur_test, test_cycles, error_count - test_start_errors);
			tests_done++;
		end

		$display("%0d tests, %0d vectors, %0d checks, %0d errors",
			tests_done, num_vectors, check_count, error_count);
		if (error_count == 0)
		begin
			$display("Verification passed");
		end
		else
		begin
			$display("Verification failed");
		end
		$finish;
	end

	// Reset plus two clock periods per vector is ample
	initial
	begin
		wait (vectors_loaded);
		#((RESET_CYCLES + 2 * num_vectors) * CLK_PERIOD);
		$display("Watchdog timeout, the vector sequence did not complete in time");
		$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

/* hw/pifo_queue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pifo_params.svh"

module pifo_queue
	import pifo_pkg::*;
(
	input  logic   clk,
	input  logic   rst,

	// Insert and remove strobes, one cycle each
	input  logic   insert,
	input  logic   remove,
	input  rank_t  rank_in,
	input  meta_t  meta_in,

	// Lowest rank entry, valid for one cycle after a remove
	output rank_t  rank_out,
	output meta_t  meta_out,
	output logic   valid_out,

	output count_t num_entries,
	output logic   full
);

	// Fills the missing neighbor at both ends of the array
	localparam pifo_entry_t EMPTY_ENTRY = '0;

	cell_op_t    op;
	pifo_entry_t head;
	pifo_entry_t cell_entry [`PIFO_DEPTH];

	pifo_ctrl u_ctrl
	(
		.clk         (clk),
		.rst         (rst),
		.insert      (insert),
		.remove      (remove),
		.rank_in     (rank_in),
		.meta_in     (meta_in),
		.head        (head),
		.op          (op),
		.rank_out    (rank_out),
		.meta_out    (meta_out),
		.valid_out   (valid_out),
		.num_entries (num_entries),
		.full        (full)
	);

	genvar i;
	generate
		for (i = 0; i < `PIFO_DEPTH; i++)
		begin : g_cell
			pifo_entry_t left;
			pifo_entry_t right;

			if (i == 0)
			begin : g_first
				assign left = EMPTY_ENTRY;
			end
			else
			begin : g_left
				assign left = cell_entry[i-1];
			end

			// Nothing shifts in behind the last cell
			if (i == `PIFO_DEPTH - 1)
			begin : g_last
				assign right = EMPTY_ENTRY;
			end
			else
			begin : g_right
				assign right = cell_entry[i+1];
			end

			pifo_cell
			#(
				.head_cell (i == 0)
			)
			u_cell
			(
				.clk   (clk),
				.rst   (rst),
				.op    (op),
				.left  (left),
				.right (right),
				.entry (cell_entry[i])
			);
		end
	endgenerate

	assign head = cell_entry[0];

endmodule

`default_nettype wire

/* hw/pifo_cell.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pifo_params.svh"

module pifo_cell
	import pifo_pkg::*;
#(
	parameter bit head_cell = 1'b0
)
(
	input  logic        clk,
	input  logic        rst,

	// Operation broadcast by the command front end
	input  cell_op_t    op,

	// Neighbors, left is closer to the head
	input  pifo_entry_t left,
	input  pifo_entry_t right,

	output pifo_entry_t entry
);

	pifo_entry_t new_entry;
	pifo_entry_t next_entry;
	logic        own_first;
	logic        left_first;
	logic        right_first;

	// True when e is valid and leaves no later than an entry of rank r
	function automatic logic leaves_first(input pifo_entry_t e, input rank_t r);
		return e.valid && (e.rank <= r);
	endfunction

	assign new_entry = op.entry;

	// Equal ranks count as first, so older entries stay ahead of new ones
	assign own_first = leaves_first(entry, new_entry.rank);
	assign right_first = leaves_first(right, new_entry.rank);

	// Nothing sits left of the head cell
	assign left_first = head_cell || leaves_first(left, new_entry.rank);

	always_comb
	begin
		case (op.op)
			OP_INSERT:
			begin
				// Entries ahead of the new one stay, the rest move one cell back
				if (own_first)
				begin
					next_entry = entry;
				end
				else if (left_first)
				begin
					next_entry = new_entry;
				end
				else
				begin
					next_entry = left;
				end
			end
			OP_REMOVE:
			begin
				// Everything shifts one cell toward the head
				next_entry = right;
			end
			OP_REPLACE:
			begin
				// Head leaves, so entries ahead of the new one shift forward
				if (right_first)
				begin
					next_entry = right;
				end
				else if (head_cell || own_first)
				begin
					next_entry = new_entry;
				end
				else
				begin
					next_entry = entry;
				end
			end
			default:
			begin
				next_entry = entry;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			entry <= '0;
		end
		else
		begin
			entry <= next_entry;
		end
	end

	// Array stays packed toward the head and sorted by rank
	if (!head_cell)
	begin : g_order_check
		assert property (@(posedge clk) disable iff (rst)
			entry.valid |-> (left.valid && (left.rank <= entry.rank)))
			else $error("pifo_cell: rank %0d behind left rank %0d", entry.rank, left.rank);
	end

endmodule

`default_nettype wire

/* hw/pifo_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pifo_params.svh"

module pifo_ctrl
	import pifo_pkg::*;
(
	input  logic        clk,
	input  logic        rst,

	// User commands
	input  logic        insert,
	input  logic        remove,
	input  rank_t       rank_in,
	input  meta_t       meta_in,

	// Entry currently held by cell 0
	input  pifo_entry_t head,

	// Broadcast to the cell array
	output cell_op_t    op,

	// Drained head entry
	output rank_t       rank_out,
	output meta_t       meta_out,
	output logic        valid_out,

	// Status
	output count_t      num_entries,
	output logic        full
);

	localparam count_t DEPTH = count_t'(`PIFO_DEPTH);

	count_t      count;
	count_t      count_next;
	logic        count_zero;
	logic        ins_ok;
	logic        rmv_ok;
	pifo_op_e    op_sel;
	pifo_entry_t new_entry;

	assign count_zero = (count == '0);

	// A remove needs something to remove
	assign rmv_ok = remove && !count_zero;

	// An insert on a full queue only goes in when the head leaves on the same edge
	assign ins_ok = insert && (!full || remove);

	// Entry offered to the cells, marked valid only when the insert is taken
	always_comb
	begin
		new_entry.valid = ins_ok;
		new_entry.rank = rank_in;
		new_entry.meta = meta_in;
	end

	// Pick the operation for this cycle
	always_comb
	begin
		case ({ins_ok, rmv_ok})
			2'b10:
			begin
				op_sel = OP_INSERT;
			end
			2'b01:
			begin
				op_sel = OP_REMOVE;
			end
			2'b11:
			begin
				op_sel = OP_REPLACE;
			end
			default:
			begin
				op_sel = OP_IDLE;
			end
		endcase
	end

	always_comb
	begin
		op.op = op_sel;
		op.entry = new_entry;
	end

	// Replace leaves the count alone
	always_comb
	begin
		case (op_sel)
			OP_INSERT:
			begin
				count_next = count + count_t'(1);
			end
			OP_REMOVE:
			begin
				count_next = count - count_t'(1);
			end
			default:
			begin
				count_next = count;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			count <= '0;
			full <= 1'b0;
		end
		else
		begin
			count <= count_next;
			full <= (count_next == DEPTH);
		end
	end

	assign num_entries = count;

	// One cycle pulse for every accepted remove
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			valid_out <= 1'b0;
		end
		else
		begin
			valid_out <= rmv_ok;
		end
	end

	// Head is captured before the array shifts, and held until the next remove
	always_ff @(posedge clk)
	begin
		if (rmv_ok)
		begin
			rank_out <= head.rank;
			meta_out <= head.meta;
		end
	end

	// Count bookkeeping never runs past the array size
	assert property (@(posedge clk) disable iff (rst) count <= DEPTH)
		else $error("pifo_ctrl: count %0d above depth", count);

	// Count and cell contents agree about an empty queue
	assert property (@(posedge clk) disable iff (rst) !count_zero |-> head.valid)
		else $error("pifo_ctrl: count %0d but head cell is empty", count);

endmodule

`default_nettype wire

/* hw/pifo_pkg.sv */
`default_nettype none

`include "pifo_params.svh"

package pifo_pkg;

	// Scheduling rank, compared unsigned
	typedef logic [`PIFO_RANK_WIDTH-1:0] rank_t;

	// Opaque payload that follows its rank through the array
	typedef logic [`PIFO_META_WIDTH-1:0] meta_t;

	// One extra bit so a full array can be counted
	typedef logic [`PIFO_L2_DEPTH:0] count_t;

	// Content of one sorting cell
	typedef struct packed
	{
		logic  valid;
		rank_t rank;
		meta_t meta;
	} pifo_entry_t;

	// Operation broadcast to every cell in a cycle
	// OP_REPLACE is a remove and an insert on the same edge
	typedef enum logic [1:0]
	{
		OP_IDLE    = 2'b00,
		OP_INSERT  = 2'b01,
		OP_REMOVE  = 2'b10,
		OP_REPLACE = 2'b11
	} pifo_op_e;

	// Operation plus the entry being inserted, if any
	typedef struct packed
	{
		pifo_op_e    op;
		pifo_entry_t entry;
	} cell_op_t;

endpackage

`default_nettype wire

/* hw/pifo_params.svh */
`ifndef PIFO_PARAMS_SVH
`define PIFO_PARAMS_SVH

// Rank carried with every entry, lower ranks leave first
`define PIFO_RANK_WIDTH 10

// Metadata word, passed through untouched
`define PIFO_META_WIDTH 10

// Number of sorting cells as a power of two
`define PIFO_L2_DEPTH 3

// Cell count of the systolic array
`define PIFO_DEPTH (1 << `PIFO_L2_DEPTH)

`endif
